// ==== build.f ====
source/lsu_pkg.sv
source/lsu_byte_lane.sv
source/lsu_data_ram.sv
source/lsu_flush_counter.sv
source/lsu_fence_fsm.sv
source/lsu_top.sv
bench/lsu_checker.sv
bench/lsu_tb.sv

// ==== Makefile ====
SOURCES := $(wildcard source/*.sv bench/*.sv)

.PHONY: all run clean

all: obj_dir/Vlsu_tb

# the stem of the binary name is the top module
obj_dir/V%: build.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $* -Mdir obj_dir -f build.f

# the checker counts its failures, so the bench decides how the run ends
run: obj_dir/Vlsu_tb
	./obj_dir/Vlsu_tb +verilator+error+limit+1000

clean:
	rm -rf obj_dir

// ==== bench/lsu_tb.sv ====
// self-checking testbench for the load-store unit that runs as the simulation top module
module lsu_tb
    import lsu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAM_BYTES     = 64 * 4;
    localparam int NUM_TESTS     = 5;
    localparam int LIMIT_CYCLES  = NUM_TESTS * 200 + 100;

    logic       CLK;
    logic       nRST;
    logic       fence;
    logic       fence_stall;
    lsu_req_t   req;
    lsu_rsp_t   rsp;
    // byte image of the data RAM that wraps like the RAM
    logic [7:0] ref_mem [RAM_BYTES];
    addr_t      words [8];
    word_t      rnd;
    int         seed = 41;

    lsu_top u_dut (
        .CLK         (CLK),
        .nRST        (nRST),
        .req         (req),
        .rsp         (rsp),
        .fence       (fence),
        .fence_stall (fence_stall)
    );

    function automatic int byte_index(addr_t a, int k);
        return int'((a + addr_t'(k)) % addr_t'(RAM_BYTES));
    endfunction

    // little-endian pick from the image, then sign or zero extension
    function automatic word_t expected_load(access_t acc, addr_t a);
        logic [7:0]  b;
        logic [15:0] h;
        b = ref_mem[byte_index(a, 0)];
        h = {ref_mem[byte_index(a, 1)], b};
        case (acc)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'b0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'b0, h};
            default: return {ref_mem[byte_index(a, 3)], ref_mem[byte_index(a, 2)], h};
        endcase
    endfunction

    task automatic check_value(string name, word_t expected, word_t actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    // one access is held until ready and then checked against the image
    task automatic run_access(logic write, access_t acc, addr_t a, word_t data, logic misaligned);
        lsu_req_t new_req;
        int       nbytes;
        new_req.ren        = !write;
        new_req.wen        = write;
        new_req.access     = acc;
        new_req.addr       = a;
        new_req.store_data = data;
        nbytes = (acc == LW) ? 4 : ((acc == LH) ? 2 : 1);
        @(posedge CLK);
        req <= new_req;
        @(posedge CLK);
        while (!rsp.ready) begin
            @(posedge CLK);
        end
        check_value("rsp.mal_addr", {31'b0, misaligned}, {31'b0, rsp.mal_addr});
        if (!write) begin
            check_value("rsp.load_data", misaligned ? '0 : expected_load(acc, a), rsp.load_data);
        end else if (!misaligned) begin
            for (int k = 0; k < nbytes; k++) begin
                ref_mem[byte_index(a, k)] = data[k*8 +: 8];
            end
        end
        req.ren <= 1'b0;
        req.wen <= 1'b0;
    endtask

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge CLK);
        $display("watchdog expired, the run hung before all tests finished");
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

    // stop at the first failed timing assertion
    always @(posedge CLK) begin
        if (u_dut.u_checker.failures != 0) begin
            $display("a timing assertion in the bound checker failed");
            $display("ERRORS FOUND");
            $fatal(1, "timing assertion failed");
        end
    end

    initial begin
        addr_t byte_addr;
        addr_t half_addr;
        nRST  = 1'b0;
        fence = 1'b0;
        req   = '0;
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;
        // whole words first, so every later byte is known
        for (int i = 0; i < 8; i++) begin
            rnd      = $random(seed);
            words[i] = {rnd[31:2], 2'b00};
            run_access(1'b1, LW, words[i], $random(seed), 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            run_access(1'b0, LW, words[i], '0, 1'b0);
        end
        // byte and half stores where the sign bits alternate over the rounds
        for (int i = 0; i < 8; i++) begin
            rnd       = $random(seed);
            rnd[7]    = i[0];
            rnd[15]   = i[1];
            byte_addr = {words[i][31:2], rnd[1:0]};
            half_addr = {words[i][31:2], rnd[2], 1'b0};
            run_access(1'b1, LB, byte_addr, rnd, 1'b0);
            run_access(1'b0, LB, byte_addr, '0, 1'b0);
            run_access(1'b0, LBU, byte_addr, '0, 1'b0);
            run_access(1'b1, LH, half_addr, rnd, 1'b0);
            run_access(1'b0, LH, half_addr, '0, 1'b0);
            run_access(1'b0, LHU, half_addr, '0, 1'b0);
            run_access(1'b0, LW, words[i], '0, 1'b0);
        end
        // misaligned loads read zero, misaligned stores leave the word alone
        run_access(1'b0, LH, {words[0][31:2], 2'b01}, '0, 1'b1);
        run_access(1'b0, LHU, {words[0][31:2], 2'b11}, '0, 1'b1);
        for (int k = 1; k < 4; k++) begin
            run_access(1'b0, LW, {words[0][31:2], k[1:0]}, '0, 1'b1);
        end
        run_access(1'b1, LH, {words[1][31:2], 2'b11}, 32'hdead_beef, 1'b1);
        run_access(1'b1, LW, {words[1][31:2], 2'b10}, 32'hcafe_f00d, 1'b1);
        run_access(1'b0, LW, words[1], '0, 1'b0);
        // fence held high past the end of each stall
        repeat (2) begin
            @(posedge CLK);
            fence <= 1'b1;
            do begin
                @(posedge CLK);
            end while (!fence_stall);
            do begin
                @(posedge CLK);
            end while (fence_stall);
            repeat (4) @(posedge CLK);
            fence <= 1'b0;
        end
        repeat (4) @(posedge CLK);
        if (u_dut.u_checker.failures == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "timing assertions failed");
        end
    end

endmodule

// ==== bench/lsu_checker.sv ====
// concurrent timing and reset assertions for the load-store unit that are bound into lsu_top
module lsu_checker
    import lsu_pkg::*;
#(
    parameter int WAIT_STATES   = 2,
    parameter int DFLUSH_CYCLES = 9
) (
    input logic     CLK,
    input logic     nRST,
    input lsu_req_t req,
    input lsu_rsp_t rsp,
    input logic     fence,
    input logic     flush_start,
    input logic     fence_stall
);
    timeunit 1ns;
    timeprecision 1ps;

    int   failures = 0;
    logic active;
    logic active_q;
    logic done_q;
    logic req_start;

    task automatic count_failure(string what);
        failures = failures + 1;
        $error("%s", what);
    endtask

    assign active    = req.ren | req.wen;
    // a request starts after an idle cycle or right after a completion
    assign req_start = active && (!active_q || done_q);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            active_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            active_q <= active;
            done_q   <= active && rsp.ready;
        end
    end

    a_reset_quiet: assert property (@(posedge CLK)
        (!nRST || $rose(nRST)) |-> rsp.ready && !fence_stall && !flush_start)
        else count_failure("ready low or fence outputs active during or right after reset");

    // ready low through the wait states, then high on the completing cycle
    a_ready_on_time: assert property (@(posedge CLK) disable iff (!nRST)
        req_start |-> !rsp.ready ##WAIT_STATES rsp.ready)
        else count_failure("ready did not rise after the wait states of a request");

    a_ready_once: assert property (@(posedge CLK) disable iff (!nRST)
        active && rsp.ready |-> $past(req_start, WAIT_STATES))
        else count_failure("ready was high at a cycle other than the completion of a request");

    // the longer data flush sets the stall length
    a_stall_window: assert property (@(posedge CLK) disable iff (!nRST)
        flush_start |=> (!flush_start && fence_stall)
            ##(DFLUSH_CYCLES - 1) fence_stall ##1 !fence_stall)
        else count_failure("flush pulse wider than one cycle or stall of the wrong length");

    a_stall_fall: assert property (@(posedge CLK) disable iff (!nRST)
        $fell(fence_stall) |-> $past(flush_start, DFLUSH_CYCLES + 1))
        else count_failure("fence stall ended at the wrong cycle");

    // a held fence must not start a second flush
    a_no_restall: assert property (@(posedge CLK) disable iff (!nRST)
        fence && $past(fence) && !fence_stall |=> !fence_stall)
        else count_failure("fence stall rose again while fence stayed high");

endmodule

bind lsu_top lsu_checker #(
    .WAIT_STATES   (WAIT_STATES),
    .DFLUSH_CYCLES (DFLUSH_CYCLES)
) u_checker (
    .CLK         (CLK),
    .nRST        (nRST),
    .req         (req),
    .rsp         (rsp),
    .fence       (fence),
    .flush_start (flush_start),
    .fence_stall (fence_stall)
);

// ==== source/lsu_top.sv ====
// load-store unit top level joining byte lanes, data RAM, fence control and both flush models
module lsu_top
    import lsu_pkg::*;
#(
    parameter int WAIT_STATES   = 2,
    parameter int RAM_WORDS     = 64,
    parameter int IFLUSH_CYCLES = 5,
    parameter int DFLUSH_CYCLES = 9
) (
    input  logic     CLK,
    input  logic     nRST,
    input  lsu_req_t req,
    output lsu_rsp_t rsp,
    input  logic     fence,
    output logic     fence_stall
);

    mem_bus_t bus;
    word_t    rdata;
    logic     busy;
    logic     flush_start;
    logic     iflush_done;
    logic     dflush_done;

    lsu_byte_lane u_byte_lane (
        .req   (req),
        .rdata (rdata),
        .busy  (busy),
        .bus   (bus),
        .rsp   (rsp)
    );

    lsu_data_ram #(
        .WAIT_STATES (WAIT_STATES),
        .RAM_WORDS   (RAM_WORDS)
    ) u_data_ram (
        .CLK   (CLK),
        .nRST  (nRST),
        .bus   (bus),
        .rdata (rdata),
        .busy  (busy)
    );

    lsu_fence_fsm u_fence_fsm (
        .CLK         (CLK),
        .nRST        (nRST),
        .fence       (fence),
        .iflush_done (iflush_done),
        .dflush_done (dflush_done),
        .flush_start (flush_start),
        .fence_stall (fence_stall)
    );

    // instruction cache flush model
    lsu_flush_counter #(
        .FLUSH_CYCLES (IFLUSH_CYCLES)
    ) u_iflush (
        .CLK         (CLK),
        .nRST        (nRST),
        .flush_start (flush_start),
        .done        (iflush_done)
    );

    // data cache flush model
    lsu_flush_counter #(
        .FLUSH_CYCLES (DFLUSH_CYCLES)
    ) u_dflush (
        .CLK         (CLK),
        .nRST        (nRST),
        .flush_start (flush_start),
        .done        (dflush_done)
    );

endmodule

// ==== source/lsu_fence_fsm.sv ====
// fence controller that issues one cache flush per fence edge and stalls until both caches finish
module lsu_fence_fsm
    import lsu_pkg::*;
(
    input  logic CLK,
    input  logic nRST,
    input  logic fence,
    input  logic iflush_done,
    input  logic dflush_done,
    output logic flush_start,
    output logic fence_stall
);

    logic         fence_q;
    fence_state_t state;
    fence_state_t next_state;
    fence_state_t finish_state;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fence_q <= 1'b0;
            state   <= FENCE_IDLE;
        end else begin
            fence_q <= fence;
            state   <= next_state;
        end
    end

    // rising edge only counts when no flush is in progress
    assign flush_start = fence & ~fence_q & (state == FENCE_IDLE);

    // park in hold while the fence is still asserted
    assign finish_state = fence ? FENCE_HOLD : FENCE_IDLE;

    always_comb begin
        next_state = state;
        case (state)
            FENCE_IDLE: begin
                if (flush_start) begin
                    next_state = FENCE_WAIT;
                end
            end
            FENCE_WAIT: begin
                if (iflush_done && dflush_done) begin
                    next_state = finish_state;
                end else if (iflush_done) begin
                    next_state = FENCE_WAIT_D;
                end else if (dflush_done) begin
                    next_state = FENCE_WAIT_I;
                end
            end
            FENCE_WAIT_I: begin
                if (iflush_done) begin
                    next_state = finish_state;
                end
            end
            FENCE_WAIT_D: begin
                if (dflush_done) begin
                    next_state = finish_state;
                end
            end
            FENCE_HOLD: begin
                if (!fence) begin
                    next_state = FENCE_IDLE;
                end
            end
            default: next_state = FENCE_IDLE;
        endcase
    end

    assign fence_stall = (state != FENCE_IDLE) && (state != FENCE_HOLD);

endmodule

// ==== source/lsu_flush_counter.sv ====
// cache flush stand-in that pulses done a fixed number of cycles after each flush request
module lsu_flush_counter #(
    parameter int FLUSH_CYCLES = 5
) (
    input  logic CLK,
    input  logic nRST,
    input  logic flush_start,
    output logic done
);

    localparam int CNT_W = (FLUSH_CYCLES > 1) ? $clog2(FLUSH_CYCLES) : 1;
    localparam logic [CNT_W-1:0] LOAD_VAL = CNT_W'(FLUSH_CYCLES - 1);

    logic             active;
    logic [CNT_W-1:0] count;

    // count runs FLUSH_CYCLES-1 down to 0 and done sits on the zero cycle
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            active <= 1'b0;
            count  <= '0;
        end else if (flush_start) begin
            active <= 1'b1;
            count  <= LOAD_VAL;
        end else if (active) begin
            if (count == '0) begin
                active <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign done = active && (count == '0);

endmodule

// ==== source/lsu_data_ram.sv ====
// word-wide data RAM with byte write enables and a fixed wait-state delay on every access
module lsu_data_ram
    import lsu_pkg::*;
#(
    parameter int WAIT_STATES = 2,
    parameter int RAM_WORDS   = 64
) (
    input  logic     CLK,
    input  logic     nRST,
    input  mem_bus_t bus,
    output word_t    rdata,
    output logic     busy
);

    localparam int IDX_W = $clog2(RAM_WORDS);
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(WAIT_STATES);

    word_t            mem [RAM_WORDS];
    logic [IDX_W-1:0] index;
    logic [CNT_W-1:0] count;
    logic             access;
    logic             complete;

    // word address that wraps at the depth
    assign index    = bus.addr[IDX_W+1:2];
    assign access   = bus.ren | bus.wen;
    assign complete = access && (count == LAST);
    assign busy     = access && (count < LAST);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (!access || complete) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // only enabled lanes are written on the completing edge
    always_ff @(posedge CLK) begin
        if (bus.wen && complete) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.byte_en[i]) begin
                    mem[index][i*8 +: 8] <= bus.wdata[i*8 +: 8];
                end
            end
        end
    end

    assign rdata = mem[index];

endmodule

// ==== source/lsu_byte_lane.sv ====
// byte-lane logic between a scalar request and the little-endian word bus of the data RAM
module lsu_byte_lane
    import lsu_pkg::*;
(
    input  lsu_req_t req,
    input  word_t    rdata,
    input  logic     busy,
    output mem_bus_t bus,
    output lsu_rsp_t rsp
);

    logic [1:0] offset;
    byte_en_t   lane_en;
    logic       mal_addr;
    word_t      lane_mask;
    word_t      masked;
    word_t      shifted;
    word_t      load_ext;
    word_t      wdata;

    assign offset = req.addr[1:0];

    // enables depend only on access type and offset, not on ren/wen
    always_comb begin
        lane_en  = 4'b0000;
        mal_addr = 1'b0;
        case (req.access)
            LB, LBU: begin
                lane_en = byte_en_t'(4'b0001 << offset);
            end
            LH, LHU: begin
                mal_addr = offset[0];
                if (offset == 2'b00) begin
                    lane_en = 4'b0011;
                end else if (offset == 2'b10) begin
                    lane_en = 4'b1100;
                end
            end
            LW: begin
                mal_addr = (offset != 2'b00);
                if (offset == 2'b00) begin
                    lane_en = 4'b1111;
                end
            end
            default: begin
                lane_en = 4'b0000;
            end
        endcase
    end

    // replicate the store value so every lane carries it
    always_comb begin
        case (req.access)
            LB:      wdata = {4{req.store_data[7:0]}};
            LH:      wdata = {2{req.store_data[15:0]}};
            LW:      wdata = req.store_data;
            default: wdata = '0;
        endcase
    end

    // keep only enabled lanes, so a misaligned load reads back zero
    assign lane_mask = {{8{lane_en[3]}}, {8{lane_en[2]}}, {8{lane_en[1]}}, {8{lane_en[0]}}};
    assign masked    = rdata & lane_mask;
    assign shifted   = masked >> {offset, 3'b000};

    always_comb begin
        case (req.access)
            LB:      load_ext = {{24{shifted[7]}}, shifted[7:0]};
            LH:      load_ext = {{16{shifted[15]}}, shifted[15:0]};
            LW:      load_ext = shifted;
            LBU:     load_ext = {24'b0, shifted[7:0]};
            LHU:     load_ext = {16'b0, shifted[15:0]};
            default: load_ext = '0;
        endcase
    end

    assign bus.ren     = req.ren;
    assign bus.wen     = req.wen;
    assign bus.addr    = req.addr;
    assign bus.byte_en = lane_en;
    assign bus.wdata   = wdata;

    assign rsp.ready     = ~busy;
    assign rsp.mal_addr  = mal_addr;
    assign rsp.load_data = load_ext;

endmodule

// ==== source/lsu_pkg.sv ====
// shared types for the load-store unit, imported by the RTL modules and the testbench
package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    // bit 0 is the lowest byte address
    typedef logic [3:0]  byte_en_t;

    // encoded like the RV32 funct3 field of loads
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } access_t;

    typedef enum logic [2:0] {
        FENCE_IDLE,
        FENCE_WAIT,
        FENCE_WAIT_I,
        FENCE_WAIT_D,
        FENCE_HOLD
    } fence_state_t;

    typedef struct packed {
        logic    ren;
        logic    wen;
        access_t access;
        addr_t   addr;
        word_t   store_data;
    } lsu_req_t;

    typedef struct packed {
        logic  ready;
        logic  mal_addr;
        word_t load_data;
    } lsu_rsp_t;

    typedef struct packed {
        logic     ren;
        logic     wen;
        addr_t    addr;
        byte_en_t byte_en;
        word_t    wdata;
    } mem_bus_t;

endpackage
